// ==== bench/lab_top_properties.sv ====
module lab_top_properties import calc_pkg::*, panel_pkg::*; (
	input logic clk,
	input logic rst_n,
	input count_t count,
	input logic [DEC_N-1:0] enc_x,
	input enc_out_t enc_out
);

	timeunit 1ns;
	timeprecision 100ps;

	// both counters step on the same tick edge
	a_up_with_down: assert property (
		@(posedge clk) disable iff (!rst_n)
		$changed(count.up) |-> $changed(count.down)
	) else $error("count.up changed without count.down");

	a_down_with_up: assert property (
		@(posedge clk) disable iff (!rst_n)
		$changed(count.down) |-> $changed(count.up)
	) else $error("count.down changed without count.up");

	a_up_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		count.up < UP_W'(COUNT_MOD)
	) else $error("count.up left the decimal range");

	a_enc_bit_set: assert property (
		@(posedge clk) disable iff (!rst_n)
		enc_out.valid |-> enc_x[enc_out.code]
	) else $error("encoder code points at a clear bit");

endmodule

bind lab_top lab_top_properties u_props (.*);

// ==== bench/lab_top_tb.sv ====
module lab_top_tb import calc_pkg::*, panel_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		alu_in_t ai;
		alu_out_t ao;
		shift_req_t sr;
		logic [31:0] sq;
		logic [2:0] dx;
		logic de;
		logic [7:0] dy;
		logic [7:0] ex;
		logic ee;
		enc_out_t eo;
	} row_t;

	logic clk;
	logic rst_n;
	alu_in_t alu_in;
	shift_req_t shift_in;
	logic [2:0] dec_x;
	logic dec_en;
	logic [7:0] enc_x;
	logic enc_en;
	logic count_en;
	logic seq_bit;
	logic seq_clr;
	alu_out_t alu_out;
	logic [31:0] shift_out;
	logic [7:0] dec_y;
	enc_out_t enc_out;
	count_t count;
	logic seq_hit;
	seg_pair_t segs;

	row_t rows[$];
	int cyc;
	int err_cnt;
	int check_cnt;
	bit timed_out;

	lab_top u_dut (.*);

	always #10 clk = ~clk;

	// clock edges since reset release
	always @(posedge clk) begin
		if (!rst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (!timed_out) begin
			check_cnt++;
			assert (got === exp) else begin
				$display("** Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
				err_cnt++;
			end
		end
	endtask

	task automatic wait_cycle(input int target, input string what);
		int n;
		n = 0;
		while (!timed_out && cyc < target) begin
			@(negedge clk);
			n++;
			if (n > 2000) begin
				$display("Timeout: clock count never reached the point for %s", what);
				timed_out = 1'b1;
			end
		end
	endtask

	// waits for the falling edge just before a tick edge
	task automatic wait_tick_slot();
		int n;
		n = 0;
		while (!timed_out && cyc % 8 != 7) begin
			@(negedge clk);
			n++;
			if (n > 20) begin
				$display("Timeout: no tick slot found for the detector input");
				timed_out = 1'b1;
			end
		end
	endtask

	function automatic logic [7:0] seg_of(input int d);
		case (d)
			0: return 8'hc0;
			1: return 8'hf9;
			2: return 8'ha4;
			3: return 8'hb0;
			4: return 8'h99;
			5: return 8'h92;
			6: return 8'h82;
			7: return 8'hf8;
			8: return 8'h80;
			default: return 8'h90;
		endcase
	endfunction

	function automatic logic [31:0] model_shift(input shift_req_t r);
		if (r.left) begin
			return r.data << r.shamt;
		end else if (r.arith) begin
			return 32'($signed(r.data) >>> r.shamt);
		end
		return r.data >> r.shamt;
	endfunction

	task automatic add_row(
		input logic [3:0] a, input logic [3:0] b, input alu_op_e op,
		input logic [3:0] res, input logic z, input logic c, input logic v,
		input logic [31:0] sd, input logic [4:0] sa, input logic sl, input logic sar,
		input logic [31:0] sq,
		input logic [2:0] dx, input logic de, input logic [7:0] dy,
		input logic [7:0] ex, input logic ee, input logic [2:0] ec, input logic ev
	);
		row_t r;
		r.ai = '{a: a, b: b, op: op};
		r.ao = '{res: res, zero: z, carry: c, overflow: v};
		r.sr = '{data: sd, shamt: sa, left: sl, arith: sar};
		r.sq = sq;
		r.dx = dx;
		r.de = de;
		r.dy = dy;
		r.ex = ex;
		r.ee = ee;
		r.eo = '{code: ec, valid: ev};
		rows.push_back(r);
	endtask

	task automatic fill_table();
		add_row(4'd7, 4'd1, ALU_ADD, 4'h8, 1'b0, 1'b0, 1'b1,
			32'h8000_0001, 5'd0, 1'b0, 1'b1, 32'h8000_0001,
			3'd0, 1'b1, 8'h01, 8'h00, 1'b1, 3'd0, 1'b0);
		add_row(4'd15, 4'd1, ALU_ADD, 4'h0, 1'b1, 1'b1, 1'b0,
			32'h8000_0000, 5'd31, 1'b0, 1'b1, 32'hffff_ffff,
			3'd7, 1'b1, 8'h80, 8'h01, 1'b1, 3'd0, 1'b1);
		add_row(4'd0, 4'd1, ALU_SUB, 4'hf, 1'b0, 1'b0, 1'b0,
			32'h8000_0000, 5'd31, 1'b0, 1'b0, 32'h0000_0001,
			3'd3, 1'b0, 8'h00, 8'hff, 1'b1, 3'd7, 1'b1);
		add_row(4'd5, 4'd0, ALU_NOT, 4'ha, 1'b0, 1'b0, 1'b0,
			32'h0000_0001, 5'd31, 1'b1, 1'b0, 32'h8000_0000,
			3'd5, 1'b1, 8'h20, 8'h0a, 1'b1, 3'd3, 1'b1);
		add_row(4'd12, 4'd10, ALU_AND, 4'h8, 1'b0, 1'b0, 1'b0,
			32'hf000_00f0, 5'd4, 1'b0, 1'b1, 32'hff00_000f,
			3'd2, 1'b1, 8'h04, 8'hff, 1'b0, 3'd0, 1'b0);
		add_row(4'd12, 4'd10, ALU_OR, 4'he, 1'b0, 1'b0, 1'b0,
			32'hf000_00f0, 5'd4, 1'b0, 1'b0, 32'h0f00_000f,
			3'd6, 1'b0, 8'h00, 8'h30, 1'b1, 3'd5, 1'b1);
		add_row(4'd12, 4'd10, ALU_XOR, 4'h6, 1'b0, 1'b0, 1'b0,
			32'h1234_5678, 5'd8, 1'b1, 1'b0, 32'h3456_7800,
			3'd1, 1'b1, 8'h02, 8'h41, 1'b1, 3'd6, 1'b1);
		add_row(4'd14, 4'd1, ALU_LT, 4'h1, 1'b0, 1'b0, 1'b0,
			32'h8000_000f, 5'd4, 1'b1, 1'b1, 32'h0000_00f0,
			3'd4, 1'b1, 8'h10, 8'h80, 1'b1, 3'd7, 1'b1);
		add_row(4'd9, 4'd9, ALU_EQ, 4'h1, 1'b0, 1'b0, 1'b0,
			32'h7000_0000, 5'd28, 1'b0, 1'b1, 32'h0000_0007,
			3'd3, 1'b1, 8'h08, 8'h06, 1'b1, 3'd2, 1'b1);
		add_row(4'd3, 4'd4, ALU_EQ, 4'h0, 1'b1, 1'b0, 1'b0,
			32'hffff_ffff, 5'd16, 1'b0, 1'b0, 32'h0000_ffff,
			3'd7, 1'b0, 8'h00, 8'h00, 1'b0, 3'd0, 1'b0);
		add_row(4'd3, 4'd15, ALU_LT, 4'h0, 1'b1, 1'b0, 1'b0,
			32'hdead_beef, 5'd0, 1'b1, 1'b0, 32'hdead_beef,
			3'd0, 1'b1, 8'h01, 8'h10, 1'b1, 3'd4, 1'b1);
		add_row(4'd5, 4'd3, ALU_SUB, 4'h2, 1'b0, 1'b1, 1'b0,
			32'h8765_4321, 5'd12, 1'b0, 1'b1, 32'hfff8_7654,
			3'd6, 1'b1, 8'h40, 8'h03, 1'b1, 3'd1, 1'b1);
	endtask

	task automatic check_segs(input int up);
		check_eq("segs", 32'(segs), 32'({seg_of(up / 10), seg_of(up % 10)}));
	endtask

	// holds one bit for a tick window and checks the hit after that tick
	task automatic feed(input logic b, input logic exp_hit);
		wait_tick_slot();
		seq_bit = b;
		@(negedge clk);
		check_eq("seq_hit", 32'(seq_hit), 32'(exp_hit));
	endtask

	task automatic clear_history();
		seq_clr = 1'b1;
		@(negedge clk);
		seq_clr = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		alu_in = '0;
		shift_in = '0;
		dec_x = '0;
		dec_en = 1'b0;
		enc_x = '0;
		enc_en = 1'b0;
		count_en = 1'b1;
		seq_bit = 1'b0;
		seq_clr = 1'b0;
		err_cnt = 0;
		check_cnt = 0;
		timed_out = 1'b0;
		void'($urandom(80671));
		fill_table();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		check_eq("count after reset", 32'(count), 32'h0);
		check_eq("seq_hit after reset", 32'(seq_hit), 32'h0);
		check_eq("segs after reset", 32'(segs), 32'hc0c0);

		for (int k = 1; k <= 105; k++) begin
			wait_cycle(8 * k, "counter tick");
			check_eq("count.up", 32'(count.up), 32'(k % 100));
			check_eq("count.down", 32'(count.down), 32'((8 - k % 8) % 8));
			@(negedge clk);
			check_segs(k % 100);
		end
		count_en = 1'b0;
		wait_cycle(cyc + 24, "frozen counter");
		check_eq("frozen count.up", 32'(count.up), 32'(105 % 100));
		check_eq("frozen count.down", 32'(count.down), 32'((8 - 105 % 8) % 8));

		foreach (rows[i]) begin
			alu_in = rows[i].ai;
			shift_in = rows[i].sr;
			dec_x = rows[i].dx;
			dec_en = rows[i].de;
			enc_x = rows[i].ex;
			enc_en = rows[i].ee;
			@(negedge clk);
			check_eq($sformatf("alu_out row %0d", i), 32'(alu_out), 32'(rows[i].ao));
			check_eq($sformatf("shift_out row %0d", i), shift_out, rows[i].sq);
			check_eq($sformatf("dec_y row %0d", i), 32'(dec_y), 32'(rows[i].dy));
			check_eq($sformatf("enc_out row %0d", i), 32'(enc_out), 32'(rows[i].eo));
		end
		for (int i = 0; i < 50; i++) begin
			shift_in.data = $urandom();
			shift_in.shamt = 5'($urandom_range(31));
			shift_in.left = 1'($urandom_range(1));
			shift_in.arith = 1'($urandom_range(1));
			@(negedge clk);
			check_eq("random shift", shift_out, model_shift(shift_in));
		end

		clear_history();
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b1);
		clear_history();
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b0);
		feed(1'b0, 1'b0);
		feed(1'b0, 1'b0);
		feed(1'b0, 1'b0);
		feed(1'b0, 1'b1);
		clear_history();
		for (int i = 0; i < 8; i++) begin
			feed(1'(i % 2), 1'b0);
		end
		// a clear in the middle of a run restarts the count of samples
		clear_history();
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b0);
		clear_history();
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b0);
		feed(1'b1, 1'b1);
		feed(1'b0, 1'b0);

		$display("checks: %0d, errors: %0d, timed out: %0d", check_cnt, err_cnt, timed_out);
		if (err_cnt == 0 && !timed_out) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== hdl/alu_4bit.sv ====
module alu_4bit import calc_pkg::*; (
	input alu_in_t in,
	output alu_out_t out
);

	logic sub;
	logic [ALU_W-1:0] b_op;
	logic [ALU_W:0] sum;
	logic ovf;
	logic lt;

	// one adder serves add, subtract and the signed compare
	always_comb begin
		sub = (in.op == ALU_SUB) || (in.op == ALU_LT);
		b_op = sub ? ~in.b : in.b;
		sum = {1'b0, in.a} + {1'b0, b_op} + {{ALU_W{1'b0}}, sub};
		ovf = (in.a[ALU_W-1] == b_op[ALU_W-1]) && (sum[ALU_W-1] != in.a[ALU_W-1]);
		// a < b when the difference is negative, corrected for overflow
		lt = sum[ALU_W-1] ^ ovf;
	end

	always_comb begin
		out = '0;
		case (in.op)
			ALU_ADD, ALU_SUB: begin
				out.res = sum[ALU_W-1:0];
				out.carry = sum[ALU_W];
				out.overflow = ovf;
			end
			ALU_NOT: begin
				out.res = ~in.a;
			end
			ALU_AND: begin
				out.res = in.a & in.b;
			end
			ALU_OR: begin
				out.res = in.a | in.b;
			end
			ALU_XOR: begin
				out.res = in.a ^ in.b;
			end
			ALU_LT: begin
				out.res = {{(ALU_W-1){1'b0}}, lt};
			end
			ALU_EQ: begin
				out.res = {{(ALU_W-1){1'b0}}, in.a == in.b};
			end
			default: begin
				out.res = '0;
			end
		endcase
		out.zero = (out.res == '0);
	end

endmodule

// ==== hdl/barrel_shifter.sv ====
module barrel_shifter import calc_pkg::*; (
	input shift_req_t req,
	output logic [SHIFT_W-1:0] q
);

	logic fill;
	logic [SHIFT_W-1:0] work;

	always_comb begin
		fill = req.arith && !req.left && req.data[SHIFT_W-1];
		// left shifts run through the right shifter on the reversed word
		work = req.left ? {<<{req.data}} : req.data;
		for (int i = 0; i < SHAMT_W; i++) begin
			if (req.shamt[i]) begin
				work = (work >> (1 << i))
					| ({SHIFT_W{fill}} & ~({SHIFT_W{1'b1}} >> (1 << i)));
			end
		end
		q = req.left ? {<<{work}} : work;
	end

endmodule

// ==== hdl/calc_pkg.sv ====
package calc_pkg;

	localparam int ALU_W = 4;
	localparam int SHIFT_W = 32;
	localparam int SHAMT_W = $clog2(SHIFT_W);
	localparam int DEC_W = 3;
	localparam int DEC_N = 1 << DEC_W;

	// LT is a signed compare, LT and EQ return 1 or 0
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_NOT = 3'd2,
		ALU_AND = 3'd3,
		ALU_OR  = 3'd4,
		ALU_XOR = 3'd5,
		ALU_LT  = 3'd6,
		ALU_EQ  = 3'd7
	} alu_op_e;

	typedef struct packed {
		logic [ALU_W-1:0] a;
		logic [ALU_W-1:0] b;
		alu_op_e op;
	} alu_in_t;

	typedef struct packed {
		logic [ALU_W-1:0] res;
		logic zero;
		logic carry;
		logic overflow;
	} alu_out_t;

	typedef struct packed {
		logic [SHIFT_W-1:0] data;
		logic [SHAMT_W-1:0] shamt;
		logic left;
		logic arith;
	} shift_req_t;

	typedef struct packed {
		logic [DEC_W-1:0] code;
		logic valid;
	} enc_out_t;

endpackage

// ==== hdl/code_converter.sv ====
module code_converter import calc_pkg::*; (
	input logic [DEC_W-1:0] dec_x,
	input logic dec_en,
	output logic [DEC_N-1:0] dec_y,
	input logic [DEC_N-1:0] enc_x,
	input logic enc_en,
	output enc_out_t enc_out
);

	always_comb begin
		dec_y = '0;
		if (dec_en) begin
			dec_y[dec_x] = 1'b1;
		end
	end

	// later bits overwrite earlier ones, so the highest set bit wins
	always_comb begin
		enc_out = '0;
		if (enc_en) begin
			for (int i = 0; i < DEC_N; i++) begin
				if (enc_x[i]) begin
					enc_out.code = DEC_W'(i);
					enc_out.valid = 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/lab_top.sv ====
module lab_top import calc_pkg::*, panel_pkg::*; (
	input logic clk,
	input logic rst_n,
	input alu_in_t alu_in,
	input shift_req_t shift_in,
	input logic [DEC_W-1:0] dec_x,
	input logic dec_en,
	input logic [DEC_N-1:0] enc_x,
	input logic enc_en,
	input logic count_en,
	input logic seq_bit,
	input logic seq_clr,
	output alu_out_t alu_out,
	output logic [SHIFT_W-1:0] shift_out,
	output logic [DEC_N-1:0] dec_y,
	output enc_out_t enc_out,
	output count_t count,
	output logic seq_hit,
	output seg_pair_t segs
);

	logic tick;

	alu_4bit u_alu (
		.in(alu_in),
		.out(alu_out)
	);

	barrel_shifter u_shifter (
		.req(shift_in),
		.q(shift_out)
	);

	code_converter u_codec (
		.dec_x(dec_x),
		.dec_en(dec_en),
		.dec_y(dec_y),
		.enc_x(enc_x),
		.enc_en(enc_en),
		.enc_out(enc_out)
	);

	tick_counters u_counters (
		.clk(clk),
		.rst_n(rst_n),
		.count_en(count_en),
		.tick(tick),
		.count(count)
	);

	seq_detector u_detector (
		.clk(clk),
		.rst_n(rst_n),
		.tick(tick),
		.seq_bit(seq_bit),
		.seq_clr(seq_clr),
		.seq_hit(seq_hit)
	);

	seg_display u_display (
		.clk(clk),
		.rst_n(rst_n),
		.up(count.up),
		.segs(segs)
	);

endmodule

// ==== hdl/panel_pkg.sv ====
package panel_pkg;

	// raise TICK_DIV for a visible rate on the board
	localparam int TICK_DIV = 8;
	localparam int DIV_W = $clog2(TICK_DIV);
	localparam int COUNT_MOD = 100;
	localparam int UP_W = 7;
	localparam int DOWN_W = 3;
	localparam int RUN_LEN = 4;
	localparam int RUN_W = $clog2(RUN_LEN + 1);

	typedef struct packed {
		logic [UP_W-1:0] up;
		logic [DOWN_W-1:0] down;
	} count_t;

	// active low, a..g in bits 0..6, dp in bit 7
	typedef struct packed {
		logic [7:0] tens;
		logic [7:0] ones;
	} seg_pair_t;

	localparam logic [7:0] SEG_OFF = 8'hff;

	localparam logic [7:0] SEG_DIGIT [10] = '{
		8'hc0,
		8'hf9,
		8'ha4,
		8'hb0,
		8'h99,
		8'h92,
		8'h82,
		8'hf8,
		8'h80,
		8'h90
	};

endpackage

// ==== hdl/seg_display.sv ====
module seg_display import panel_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [UP_W-1:0] up,
	output seg_pair_t segs
);

	logic [3:0] tens;
	logic [3:0] ones;

	// digits above 9 cannot come from the counter, show them blank
	function automatic logic [7:0] digit_seg(input logic [3:0] d);
		if (d < 4'd10) begin
			return SEG_DIGIT[d];
		end
		return SEG_OFF;
	endfunction

	always_comb begin
		tens = 4'(up / 10);
		ones = 4'(up % 10);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			segs.tens <= SEG_DIGIT[0];
			segs.ones <= SEG_DIGIT[0];
		end else begin
			segs.tens <= digit_seg(tens);
			segs.ones <= digit_seg(ones);
		end
	end

endmodule

// ==== hdl/seq_detector.sv ====
module seq_detector import panel_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic tick,
	input logic seq_bit,
	input logic seq_clr,
	output logic seq_hit
);

	logic [RUN_W-1:0] n_samples;
	logic [RUN_W-1:0] run_len;
	logic [RUN_W-1:0] run_next;
	logic last_bit;

	// run length including the sample taken on this tick
	always_comb begin
		if (n_samples == '0 || seq_bit != last_bit) begin
			run_next = RUN_W'(1);
		end else if (run_len == RUN_W'(RUN_LEN)) begin
			run_next = run_len;
		end else begin
			run_next = run_len + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || seq_clr) begin
			n_samples <= '0;
			run_len <= '0;
			seq_hit <= 1'b0;
		end else if (tick) begin
			if (n_samples != RUN_W'(RUN_LEN)) begin
				n_samples <= n_samples + 1'b1;
			end
			run_len <= run_next;
			seq_hit <= (run_next == RUN_W'(RUN_LEN));
		end
	end

	// only meaningful once n_samples is nonzero
	always_ff @(posedge clk) begin
		if (tick) begin
			last_bit <= seq_bit;
		end
	end

endmodule

// ==== hdl/tick_counters.sv ====
module tick_counters import panel_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic count_en,
	output logic tick,
	output count_t count
);

	logic [DIV_W-1:0] div_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// one cycle in every TICK_DIV
	assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (tick && count_en) begin
			if (count.up == UP_W'(COUNT_MOD - 1)) begin
				count.up <= '0;
			end else begin
				count.up <= count.up + 1'b1;
			end
			// wraps through its own width
			count.down <= count.down - 1'b1;
		end
	end

endmodule

// ==== logic_lab.f ====
hdl/calc_pkg.sv
hdl/panel_pkg.sv
hdl/alu_4bit.sv
hdl/barrel_shifter.sv
hdl/code_converter.sv
hdl/tick_counters.sv
hdl/seq_detector.sv
hdl/seg_display.sv
hdl/lab_top.sv
bench/lab_top_properties.sv
bench/lab_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the logic_lab testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module lab_top_tb \
	-f logic_lab.f \
	-o lab_top_sim

./obj_dir/lab_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
exit 0
